/* common/core_pkg.sv */
package core_pkg;

	////////////////////////////////////////
	// widths
	localparam int WORD_W  = 32;      // data and instruction word
	localparam int REG_AW  = 5;       // register address
	localparam int REG_N   = 32;      // register count
	localparam int ALUOP_W = 4;
	localparam int BC_W    = 2;
	localparam int DST_W   = 2;
	localparam int ST_W    = 3;
	localparam int CW_W    = 15;      // packed control word from the decoder tables

	localparam logic [REG_AW-1:0] REG_RA = 5'd31;   // link register

	////////////////////////////////////////
	// alu operation codes
	localparam logic [ALUOP_W-1:0] ALU_AND  = 4'b0000;
	localparam logic [ALUOP_W-1:0] ALU_OR   = 4'b0001;
	localparam logic [ALUOP_W-1:0] ALU_ADD  = 4'b0010;
	localparam logic [ALUOP_W-1:0] ALU_XOR  = 4'b0011;
	localparam logic [ALUOP_W-1:0] ALU_NOR  = 4'b0100;
	localparam logic [ALUOP_W-1:0] ALU_SRL  = 4'b0101;
	localparam logic [ALUOP_W-1:0] ALU_SUB  = 4'b0110;
	localparam logic [ALUOP_W-1:0] ALU_SLT  = 4'b0111;
	localparam logic [ALUOP_W-1:0] ALU_SLL  = 4'b1000;
	localparam logic [ALUOP_W-1:0] ALU_SRA  = 4'b1001;
	localparam logic [ALUOP_W-1:0] ALU_SLTU = 4'b1010;

	// branch condition
	localparam logic [BC_W-1:0] BC_NO = 2'b00;
	localparam logic [BC_W-1:0] BC_EQ = 2'b01;
	localparam logic [BC_W-1:0] BC_NE = 2'b10;

	// destination register select
	localparam logic [DST_W-1:0] DST_NO = 2'b00;
	localparam logic [DST_W-1:0] DST_RA = 2'b01;   // r31
	localparam logic [DST_W-1:0] DST_RT = 2'b10;
	localparam logic [DST_W-1:0] DST_RD = 2'b11;

	// sequencer states
	localparam logic [ST_W-1:0] ST_REQ   = 3'd0;
	localparam logic [ST_W-1:0] ST_DROP  = 3'd1;
	localparam logic [ST_W-1:0] ST_EXEC  = 3'd2;
	localparam logic [ST_W-1:0] ST_WRITE = 3'd3;
	localparam logic [ST_W-1:0] ST_HALT  = 3'd4;

	// opcode / funct values the decoder selects on
	localparam logic [5:0] OP_SPECIAL = 6'h00;
	localparam logic [5:0] FN_SYSCALL = 6'h0c;

	// unlisted encoding, only halt set
	localparam logic [CW_W-1:0] CW_BAD = 15'b00_0_0_0_0_0000_0_0_00_1;

	////////////////////////////////////////
	// instruction word, two layouts
	typedef union packed {
		struct packed {
			logic [5:0] op;
			logic [4:0] rs;
			logic [4:0] rt;
			logic [4:0] rd;
			logic [4:0] shamt;
			logic [5:0] funct;
		} r;                       // register layout
		struct packed {
			logic [5:0]  op;
			logic [4:0]  rs;
			logic [4:0]  rt;
			logic [15:0] imm16;        // low 26 bits also jump index
		} i;                       // immediate / jump layout
	} inst_u;

endpackage

/* common/dec_if.sv */
`timescale 1ns/10ps
interface dec_if;
	import core_pkg::*;

	logic [BC_W-1:0]    bcond;      // BC_* code
	logic               j;          // j / jal
	logic               jr;         // jump to rs
	logic               src_imm;    // b operand from immediate
	logic               imm_sign;   // sign extend imm16
	logic [ALUOP_W-1:0] aluop;
	logic               lui;        // imm16 into upper half
	logic               link;       // write pc+4
	logic [DST_W-1:0]   wb_dst;     // DST_* code
	logic               halt;       // syscall or unknown
	inst_u              ir;         // captured instruction word

	// decoder side
	modport ctl (
		input  ir,
		output bcond, j, jr, src_imm, imm_sign, aluop, lui, link, wb_dst, halt
	);

	// sequencer owns ir
	modport fsm (output ir, input halt);

	// datapath readers
	modport dp (
		input ir, bcond, j, jr, src_imm, imm_sign, aluop, lui, link, wb_dst
	);

endinterface

/* compile.f */
common/core_pkg.sv
common/dec_if.sv
control/control.sv
control/seq_fsm.sv
src/pc_counter.sv
src/reg_file.sv
src/alu.sv
src/mips_core.sv
verification/mips_core_assert.sv
verification/tb_mips_core.sv

/* control/control.sv */
`timescale 1ns/10ps
module control (
	dec_if.ctl ctl
);
	import core_pkg::*;

	logic [CW_W-1:0] lut_fun [64];   // op 0, indexed by funct
	logic [CW_W-1:0] lut_op [64];    // all other opcodes
	logic [CW_W-1:0] cw_sys;         // syscall word
	logic [CW_W-1:0] cw;             // selected word
	logic [5:0]      op;
	logic [5:0]      fn;
	logic            sel_fun;
	logic            sel_sys;

	assign op = ctl.ir.r.op;
	assign fn = ctl.ir.r.funct;

	////////////////////////////////////////
	// tables
	// layout bc_j_jr_imm_sgn_aluop_lui_lnk_dst_halt

	initial begin
		for (int k = 0; k < 64; k++)
			lut_fun[k] = CW_BAD;                           // unknown
		lut_fun[6'h00] = 15'b00_0_0_0_0_1000_0_0_11_0;  // sll
		lut_fun[6'h02] = 15'b00_0_0_0_0_0101_0_0_11_0;  // srl
		lut_fun[6'h03] = 15'b00_0_0_0_0_1001_0_0_11_0;  // sra
		lut_fun[6'h08] = 15'b00_0_1_0_0_0000_0_0_00_0;  // jr
		lut_fun[6'h20] = 15'b00_0_0_0_0_0010_0_0_11_0;  // add
		lut_fun[6'h21] = 15'b00_0_0_0_0_0010_0_0_11_0;  // addu
		lut_fun[6'h22] = 15'b00_0_0_0_0_0110_0_0_11_0;  // sub
		lut_fun[6'h23] = 15'b00_0_0_0_0_0110_0_0_11_0;  // subu
		lut_fun[6'h24] = 15'b00_0_0_0_0_0000_0_0_11_0;  // and
		lut_fun[6'h25] = 15'b00_0_0_0_0_0001_0_0_11_0;  // or
		lut_fun[6'h26] = 15'b00_0_0_0_0_0011_0_0_11_0;  // xor
		lut_fun[6'h27] = 15'b00_0_0_0_0_0100_0_0_11_0;  // nor
		lut_fun[6'h2a] = 15'b00_0_0_0_0_0111_0_0_11_0;  // slt
		lut_fun[6'h2b] = 15'b00_0_0_0_0_1010_0_0_11_0;  // sltu
	end

	initial begin
		for (int k = 0; k < 64; k++)
			lut_op[k] = CW_BAD;                            // unknown
		lut_op[6'h02] = 15'b00_1_0_0_0_0000_0_0_00_0;   // j
		lut_op[6'h03] = 15'b00_1_0_0_0_0000_0_1_01_0;   // jal, pc+4 to r31
		lut_op[6'h04] = 15'b01_0_0_0_0_0110_0_0_00_0;   // beq
		lut_op[6'h05] = 15'b10_0_0_0_0_0110_0_0_00_0;   // bne
		lut_op[6'h08] = 15'b00_0_0_1_1_0010_0_0_10_0;   // addi
		lut_op[6'h09] = 15'b00_0_0_1_1_0010_0_0_10_0;   // addiu
		lut_op[6'h0a] = 15'b00_0_0_1_1_0111_0_0_10_0;   // slti
		lut_op[6'h0b] = 15'b00_0_0_1_1_1010_0_0_10_0;   // sltiu, still sign extended
		lut_op[6'h0c] = 15'b00_0_0_1_0_0000_0_0_10_0;   // andi
		lut_op[6'h0d] = 15'b00_0_0_1_0_0001_0_0_10_0;   // ori
		lut_op[6'h0e] = 15'b00_0_0_1_0_0011_0_0_10_0;   // xori
		lut_op[6'h0f] = 15'b00_0_0_1_0_0000_1_0_10_0;   // lui
	end

	initial begin
		cw_sys = 15'b00_0_0_0_0_0000_0_0_00_1;          // syscall stops the core
	end

	////////////////////////////////////////
	// word select

	assign sel_sys = (op == OP_SPECIAL) && (fn == FN_SYSCALL);
	assign sel_fun = (op == OP_SPECIAL) && (fn != FN_SYSCALL);

	always_comb begin
		cw = lut_op[op];               // default path
		if (sel_fun)
			cw = lut_fun[fn];
		if (sel_sys)
			cw = cw_sys;
	end

	assign {ctl.bcond, ctl.j, ctl.jr,
		ctl.src_imm, ctl.imm_sign, ctl.aluop, ctl.lui, ctl.link,
		ctl.wb_dst, ctl.halt} = cw;

endmodule

/* control/seq_fsm.sv */
`timescale 1ns/10ps
module seq_fsm (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        inst_req,
	input  logic                        inst_ack,
	input  logic [core_pkg::WORD_W-1:0] inst,
	dec_if.fsm                          d,
	output logic                        load_ir,
	output logic                        exec_en,
	output logic                        write_en,
	output logic                        halted
);
	import core_pkg::*;

	logic [ST_W-1:0] state;
	logic [ST_W-1:0] state_nxt;
	logic            req_q;       // fetch request flop

	////////////////////////////////////////
	// state decode

	assign load_ir  = (state == ST_REQ) && req_q && inst_ack;  // word valid, take it
	assign exec_en  = (state == ST_EXEC);
	assign write_en = (state == ST_WRITE);   // one cycle per instruction
	assign halted   = (state == ST_HALT);
	assign inst_req = req_q;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_REQ: begin
				if (load_ir)
					state_nxt = ST_DROP;
			end
			ST_DROP: begin
				if (!inst_ack)          // host has released ack
					state_nxt = ST_EXEC;
			end
			ST_EXEC: begin
				state_nxt = d.halt ? ST_HALT : ST_WRITE;
			end
			ST_WRITE: begin
				state_nxt = ST_REQ;
			end
			default: begin
				state_nxt = ST_HALT;    // stuck until reset
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= ST_REQ;
			req_q <= 1'b0;
		end else begin
			state <= state_nxt;
			if (load_ir)
				req_q <= 1'b0;          // drop req after capture
			else if (state_nxt == ST_REQ && !inst_ack)
				req_q <= 1'b1;          // raise only with ack low
		end
	end

	////////////////////////////////////////
	// instruction register

	always_ff @(posedge clk) begin
		if (load_ir)
			d.ir <= inst;
	end

endmodule

/* run_sim.sh */
#!/bin/sh
set -e
verilator --binary --timing --assert --top-module tb_mips_core -f compile.f
out=$(./obj_dir/Vtb_mips_core) || true
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qx "test passed"

/* src/alu.sv */
`timescale 1ns/10ps
module alu (
	dec_if.dp                           d,
	input  logic [core_pkg::WORD_W-1:0] a,
	input  logic [core_pkg::WORD_W-1:0] b,
	output logic [core_pkg::WORD_W-1:0] result,
	output logic                        zero
);
	import core_pkg::*;

	logic [WORD_W-1:0] imm_ext;   // extended imm16
	logic [WORD_W-1:0] op_b;      // second operand
	logic [4:0]        sh;        // shift amount

	assign sh = d.ir.r.shamt;

	always_comb begin
		if (d.imm_sign)
			imm_ext = {{(WORD_W-16){d.ir.i.imm16[15]}}, d.ir.i.imm16};
		else
			imm_ext = {{(WORD_W-16){1'b0}}, d.ir.i.imm16};
	end

	assign op_b = d.src_imm ? imm_ext : b;

	always_comb begin
		case (d.aluop)
			ALU_AND:  result = a & op_b;
			ALU_OR:   result = a | op_b;
			ALU_ADD:  result = a + op_b;   // no overflow trap
			ALU_XOR:  result = a ^ op_b;
			ALU_NOR:  result = ~(a | op_b);
			ALU_SRL:  result = op_b >> sh;
			ALU_SUB:  result = a - op_b;
			ALU_SLT:  result = {{(WORD_W-1){1'b0}}, $signed(a) < $signed(op_b)};
			ALU_SLL:  result = op_b << sh;
			ALU_SRA:  result = $unsigned($signed(op_b) >>> sh);
			ALU_SLTU: result = {{(WORD_W-1){1'b0}}, a < op_b};
			default:  result = '0;
		endcase
		if (d.lui)
			result = {d.ir.i.imm16, {(WORD_W-16){1'b0}}};   // upper half
	end

	assign zero = (a == op_b);   // beq / bne compare

endmodule

/* src/mips_core.sv */
`timescale 1ns/10ps
module mips_core (
	input  logic                        clk,
	input  logic                        rst_n,
	output logic                        inst_req,
	output logic [core_pkg::WORD_W-1:0] pc,
	input  logic [core_pkg::WORD_W-1:0] inst,
	input  logic                        inst_ack,
	output logic                        wb_valid,
	output logic [core_pkg::REG_AW-1:0] wb_addr,
	output logic [core_pkg::WORD_W-1:0] wb_data,
	output logic                        halted
);
	import core_pkg::*;

	logic              load_ir;
	logic              exec_en;
	logic              write_en;
	logic              zero;
	logic              wen_q;      // instruction writes a register
	logic [WORD_W-1:0] ra_data;
	logic [WORD_W-1:0] rb_data;
	logic [WORD_W-1:0] alu_res;
	logic [WORD_W-1:0] pc4;
	logic [REG_AW-1:0] wa_nxt;

	dec_if i_dec_if ();

	control i_control (.ctl(i_dec_if.ctl));

	seq_fsm i_seq_fsm (
		.clk(clk), .rst_n(rst_n), .inst_req(inst_req), .inst_ack(inst_ack),
		.inst(inst), .d(i_dec_if.fsm), .load_ir(load_ir), .exec_en(exec_en),
		.write_en(write_en), .halted(halted)
	);

	pc_counter i_pc_counter (
		.clk(clk), .rst_n(rst_n), .write_en(write_en), .d(i_dec_if.dp),
		.rs_val(ra_data), .zero(zero), .pc(pc), .pc4(pc4)
	);

	reg_file i_reg_file (
		.clk(clk), .rst_n(rst_n), .ra_addr(i_dec_if.ir.r.rs), .rb_addr(i_dec_if.ir.r.rt),
		.ra_data(ra_data), .rb_data(rb_data), .we(wb_valid), .w_addr(wb_addr),
		.w_data(wb_data)
	);

	alu i_alu (.d(i_dec_if.dp), .a(ra_data), .b(rb_data), .result(alu_res), .zero(zero));

	////////////////////////////////////////
	// write select, result register

	always_comb begin
		case (i_dec_if.wb_dst)
			DST_RA:  wa_nxt = REG_RA;
			DST_RT:  wa_nxt = i_dec_if.ir.r.rt;
			DST_RD:  wa_nxt = i_dec_if.ir.r.rd;
			default: wa_nxt = '0;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wen_q   <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
		end else if (load_ir) begin   // port idles at zero during fetch
			wen_q   <= 1'b0;
			wb_addr <= '0;
			wb_data <= '0;
		end else if (exec_en) begin
			wen_q   <= (i_dec_if.wb_dst != DST_NO);
			wb_addr <= wa_nxt;
			wb_data <= i_dec_if.link ? pc4 : alu_res;   // jal link value
		end
	end

	assign wb_valid = write_en & wen_q;   // also the register file write

endmodule

/* src/pc_counter.sv */
`timescale 1ns/10ps
module pc_counter (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        write_en,
	dec_if.dp                           d,
	input  logic [core_pkg::WORD_W-1:0] rs_val,
	input  logic                        zero,
	output logic [core_pkg::WORD_W-1:0] pc,
	output logic [core_pkg::WORD_W-1:0] pc4
);
	import core_pkg::*;

	logic [WORD_W-1:0] br_off;     // branch offset in bytes
	logic [WORD_W-1:0] j_tgt;      // jump region target
	logic [WORD_W-1:0] pc_nxt;
	logic              taken;

	assign pc4    = pc + WORD_W'(4);   // also the jal link value
	assign br_off = {{(WORD_W-18){d.ir.i.imm16[15]}}, d.ir.i.imm16, 2'b00};
	assign j_tgt  = {pc4[WORD_W-1:WORD_W-4], d.ir.i.rs, d.ir.i.rt, d.ir.i.imm16, 2'b00};

	always_comb begin
		case (d.bcond)
			BC_EQ:   taken = zero;
			BC_NE:   taken = ~zero;
			default: taken = 1'b0;   // BC_NO
		endcase
	end

	always_comb begin
		if (d.jr)
			pc_nxt = rs_val;
		else if (d.j)
			pc_nxt = j_tgt;
		else if (taken)
			pc_nxt = pc4 + br_off;
		else
			pc_nxt = pc4;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			pc <= '0;
		else if (write_en)           // end of WRITE only
			pc <= pc_nxt;
	end

endmodule

/* src/reg_file.sv */
`timescale 1ns/10ps
module reg_file (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic [core_pkg::REG_AW-1:0] ra_addr,
	input  logic [core_pkg::REG_AW-1:0] rb_addr,
	output logic [core_pkg::WORD_W-1:0] ra_data,
	output logic [core_pkg::WORD_W-1:0] rb_data,
	input  logic                        we,
	input  logic [core_pkg::REG_AW-1:0] w_addr,
	input  logic [core_pkg::WORD_W-1:0] w_data
);
	import core_pkg::*;

	logic [WORD_W-1:0] regs [REG_N];
	logic              wr_ok;       // r0 never written

	assign wr_ok = we && (w_addr != '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int k = 0; k < REG_N; k++)
				regs[k] <= '0;          // all registers start at zero
		end else if (wr_ok) begin
			regs[w_addr] <= w_data;
		end
	end

	// async reads
	assign ra_data = regs[ra_addr];
	assign rb_data = regs[rb_addr];

endmodule

/* verification/mips_core_assert.sv */
`timescale 1ns/10ps
module mips_core_assert (
	input logic clk,
	input logic rst_n,
	input logic inst_req,
	input logic inst_ack,
	input logic wb_valid,
	input logic halted
);

	// req held until the host acks
	req_until_ack: assert property (@(posedge clk) disable iff (!rst_n)
		$fell(inst_req) |-> $past(inst_ack))
		else $error("inst_req fell before inst_ack rose");

	// new request only once ack is released
	req_after_release: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(inst_req) |-> !$past(inst_ack))
		else $error("inst_req rose while inst_ack was still high");

	// write-back never during a fetch
	wb_not_in_fetch: assert property (@(posedge clk) disable iff (!rst_n)
		!(wb_valid && inst_req))
		else $error("wb_valid and inst_req high together");

	quiet_in_reset: assert property (@(posedge clk)
		!rst_n |-> !inst_req && !wb_valid && !halted)
		else $error("control output active during reset");

endmodule

bind mips_core mips_core_assert i_mips_core_assert (.*);

/* verification/tb_mips_core.sv */
`timescale 1ns/10ps
module tb_mips_core;
	import core_pkg::*;

	// funct values for random register ops, a few repeated
	localparam logic [5:0] RR_FN [16] = '{6'h20, 6'h21, 6'h22, 6'h23, 6'h24, 6'h25, 6'h26,
		6'h27, 6'h2a, 6'h2b, 6'h00, 6'h02, 6'h03, 6'h2a, 6'h2b, 6'h27};

	logic              clk;
	logic              rst_n;
	logic              inst_req;
	logic [WORD_W-1:0] pc;
	logic [WORD_W-1:0] inst;
	logic              inst_ack;
	logic              wb_valid;
	logic [REG_AW-1:0] wb_addr;
	logic [WORD_W-1:0] wb_data;
	logic              halted;
	integer            seed = 76;
	int                errors = 0;
	int                checks = 0;
	string             stall_why = "";  // set by a wait that ran out
	logic [WORD_W-1:0] prog [256];      // program image, indexed by pc[9:2]
	logic [WORD_W-1:0] mregs [REG_N];   // model registers
	logic [WORD_W-1:0] mpc;             // model pc

	mips_core i_mips_core (.*);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	////////////////////////////////////////
	// compare tasks

	task automatic check_bit(input string what, input logic got, input logic exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic check_pc(input logic [WORD_W-1:0] got, input logic [WORD_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("error %0t: fetch from pc %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_wb(input logic [REG_AW-1:0] got_a, input logic [WORD_W-1:0] got_d,
		input logic [REG_AW-1:0] exp_a, input logic [WORD_W-1:0] exp_d);
		checks++;
		if (got_a !== exp_a || got_d !== exp_d) begin
			errors++;
			$display("error %0t: write r%0d = %h, expected r%0d = %h",
				$time, got_a, got_d, exp_a, exp_d);
		end
	endtask

	task automatic finish_run(input string why);
		if (why != "")
			$display("timeout, %s", why);   // stalled wait
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0 && why == "")
			$display("test passed");
		else
			$display("test failed");
		$finish;
	endtask

	////////////////////////////////////////
	// stimulus and reference model

	// kind 0 register ops, 1 immediate ops, 2 branches and jumps mixed with alu ops
	function automatic logic [WORD_W-1:0] gen_inst(input int kind);
		logic [WORD_W-1:0] r;
		logic [4:0]        rs;
		logic [4:0]        rt;
		logic [4:0]        rd;
		logic [WORD_W-1:0] rr;
		logic [WORD_W-1:0] ii;
		logic [WORD_W-1:0] w;
		r  = $random(seed);
		rs = {2'b00, r[2:0]};   // r0..r7 so results get reused
		rt = {2'b00, r[5:3]};
		rd = {2'b00, r[8:6]};   // rd of 0 now and then
		rr = {6'h00, rs, rt, rd, r[25:21], RR_FN[r[19:16]]};
		ii = {3'b001, r[15:13], rs, rt, r[31:16]};   // ops 0x08..0x0f
		w  = (kind == 0) ? rr : ii;
		if (kind == 2) begin
			case (r[12:10])
				3'd0, 3'd1: w = {5'b00010, r[13], rs, rt, r[31:16]};   // beq / bne
				3'd2:       w = {5'b00001, r[13], 26'($random(seed))};  // j / jal
				3'd3:       w = {6'h00, rs, 15'd0, 6'h08};              // jr
				3'd4:       w = rr;
				default:    w = ii;
			endcase
		end
		return w;
	endfunction

	task automatic model_step(input logic [WORD_W-1:0] w, output logic wb,
		output logic [REG_AW-1:0] wa, output logic [WORD_W-1:0] wd, output logic hlt);
		logic [5:0]        op;
		logic [5:0]        fn;
		logic [WORD_W-1:0] s;
		logic [WORD_W-1:0] t;
		logic [WORD_W-1:0] se;
		logic [WORD_W-1:0] ze;
		logic [WORD_W-1:0] nxt;
		op  = w[31:26];
		fn  = w[5:0];
		s   = mregs[w[25:21]];
		t   = mregs[w[20:16]];
		se  = {{16{w[15]}}, w[15:0]};
		ze  = {16'h0000, w[15:0]};
		nxt = mpc + 32'd4;
		wd  = mpc + 32'd4;   // link value unless overwritten
		hlt = 1'b0;
		wa  = (op == 6'h00) ? w[15:11] : ((op == 6'h03) ? 5'd31 : w[20:16]);
		wb  = !(op inside {6'h02, 6'h04, 6'h05}) && !(op == 6'h00 && fn == 6'h08);
		case (op)
			6'h00: begin
				case (fn)
					6'h00:        wd = t << w[10:6];
					6'h02:        wd = t >> w[10:6];
					6'h03:        wd = $signed(t) >>> w[10:6];
					6'h08:        nxt = s;   // jr
					6'h20, 6'h21: wd = s + t;
					6'h22, 6'h23: wd = s - t;
					6'h24:        wd = s & t;
					6'h25:        wd = s | t;
					6'h26:        wd = s ^ t;
					6'h27:        wd = ~(s | t);
					6'h2a:        wd = {31'd0, $signed(s) < $signed(t)};
					6'h2b:        wd = {31'd0, s < t};
					default:      hlt = 1'b1;   // syscall or unknown funct
				endcase
			end
			6'h02, 6'h03: nxt = {nxt[31:28], w[25:0], 2'b00};
			6'h04: if (s == t) nxt = nxt + (se << 2);
			6'h05: if (s != t) nxt = nxt + (se << 2);
			6'h08, 6'h09: wd = s + se;
			6'h0a: wd = {31'd0, $signed(s) < $signed(se)};
			6'h0b: wd = {31'd0, s < se};   // compare against sign-extended imm
			6'h0c: wd = s & ze;
			6'h0d: wd = s | ze;
			6'h0e: wd = s ^ ze;
			6'h0f: wd = {w[15:0], 16'h0000};
			default: hlt = 1'b1;
		endcase
		if (!hlt && wb && wa != 5'd0)
			mregs[wa] = wd;   // r0 stays zero
		if (!hlt)
			mpc = nxt;
	endtask

	// host side of the four-phase fetch
	task automatic fetch(output logic [WORD_W-1:0] w);
		int t;
		t = 0;
		w = '0;
		@(negedge clk);
		while (!inst_req) begin
			t++;
			if (t > 20) begin
				stall_why = "inst_req never rose";
				return;
			end
			@(negedge clk);
		end
		check_pc(pc, mpc);
		repeat ({$random(seed)} % 6) @(negedge clk);   // host latency 0..5
		w        = prog[pc[9:2]];
		inst     = w;
		inst_ack = 1'b1;
		t        = 0;
		@(negedge clk);
		while (inst_req) begin
			t++;
			if (t > 20) begin
				stall_why = "inst_req stayed high after inst_ack";
				return;
			end
			@(negedge clk);
		end
		inst_ack = 1'b0;
		inst     = $random(seed);   // junk on the bus between fetches
	endtask

	task automatic run_test(input string name, input int kind, input int steps,
		input logic [WORD_W-1:0] stop);
		int                err0;
		int                t;
		logic [WORD_W-1:0] w;
		logic              ewb;
		logic [REG_AW-1:0] ea;
		logic [WORD_W-1:0] ed;
		logic              ehlt;
		err0 = errors;
		for (int k = 0; k < 256; k++)
			prog[k] = gen_inst(kind);
		for (int k = 1; k < 8; k++) begin   // load r1..r7 with lui / ori
			prog[2*k-2] = {6'h0f, 5'd0, 5'(k), 16'($random(seed))};
			prog[2*k-1] = {6'h0d, 5'(k), 5'(k), 16'($random(seed))};
		end
		if (stop != '0)
			prog[20] = stop;   // reached in order, no jumps in kinds 0 and 1
		rst_n = 1'b0;
		for (int k = 0; k < REG_N; k++)
			mregs[k] = '0;
		mpc  = '0;
		ehlt = 1'b0;
		repeat (10) @(negedge clk);
		rst_n = 1'b1;
		for (int n = 0; n < steps && !ehlt; n++) begin
			fetch(w);
			if (stall_why != "")
				return;
			model_step(w, ewb, ea, ed, ehlt);
			t = 0;
			@(negedge clk);
			while (!(wb_valid || inst_req || halted)) begin
				t++;
				if (t > 10) begin
					stall_why = "no write, fetch or halt after execute";
					return;
				end
				@(negedge clk);
			end
			check_bit("halted", halted, ehlt);
			if (!ehlt && !halted)
				check_bit("wb_valid", wb_valid, ewb);
			if (ewb && wb_valid && !ehlt)
				check_wb(wb_addr, wb_data, ea, ed);
		end
		if (stop != '0) begin
			repeat (30) begin   // core must stay quiet once halted
				@(negedge clk);
				check_bit("inst_req after halt", inst_req, 1'b0);
				check_bit("wb_valid after halt", wb_valid, 1'b0);
			end
		end
		$display("%s: %s", name, (errors == err0) ? "ok" : "mismatch");
	endtask

	initial begin
		rst_n    = 1'b0;
		inst     = '0;
		inst_ack = 1'b0;
		run_test("rr_alu", 0, 80, '0);
		if (stall_why == "")
			run_test("imm_alu", 1, 80, '0);
		if (stall_why == "")
			run_test("branch_jump", 2, 120, '0);
		if (stall_why == "")
			run_test("halt_syscall", 0, 40, {6'h00, 20'h00000, 6'h0c});
		if (stall_why == "")
			run_test("halt_unknown", 1, 40, {6'h3f, 26'h0000000});
		finish_run(stall_why);
	end

endmodule
